//--- logic/cpu_pkg.sv
package cpu_pkg;

    // data path widths
    localparam int word_data_w = 32;            // one machine word
    localparam int reg_addr_w  = 5;             // 32 general registers

    // byte offset inside a word, word accesses only
    localparam int byte_off_w  = 2;

    // local data ram
    localparam int ram_depth   = 256;           // words
    localparam int ram_addr_w  = $clog2(ram_depth);

    // memory operation carried down from decode
    typedef enum logic [1:0] {
        mem_op_nop = 2'd0,                      // alu result passes through
        mem_op_ldw = 2'd1,                      // load word
        mem_op_stw = 2'd2                       // store word
    } mem_op_t;

    // polarity helpers
    // active-high controls compare against enable,
    // the active-low write enable idles at disable_
    localparam logic enable   = 1'b1;
    localparam logic disable_ = 1'b1;

endpackage

//--- logic/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                            clk,
    input  logic [cpu_pkg::ram_addr_w-1:0]  addr,       // word index
    input  logic [cpu_pkg::word_data_w-1:0] wr_data,
    input  logic                            we,         // active high
    output logic [cpu_pkg::word_data_w-1:0] rd_data
);

    import cpu_pkg::*;

    // storage, contents undefined until written
    logic [word_data_w-1:0] mem [ram_depth];

    // write on the rising edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wr_data;
        end
    end

    // async read, a store at edge N is visible to a load right after it
    assign rd_data = mem[addr];

endmodule

//--- logic/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
    // slot coming out of EX/MEM
    input  logic                            ex_en,
    input  cpu_pkg::mem_op_t                ex_mem_op,
    input  logic [cpu_pkg::word_data_w-1:0] ex_out,          // alu result / byte address
    input  logic [cpu_pkg::word_data_w-1:0] ex_mem_wr_data,  // store data
    // pipeline control
    input  logic                            stall,
    input  logic                            flush,
    // data ram port
    input  logic [cpu_pkg::word_data_w-1:0] ram_rd_data,
    output logic [cpu_pkg::ram_addr_w-1:0]  ram_addr,
    output logic [cpu_pkg::word_data_w-1:0] ram_wr_data,
    output logic                            ram_we,
    // toward MEM/WB
    output logic [cpu_pkg::word_data_w-1:0] out,
    output logic                            miss_align
);

    import cpu_pkg::*;

    logic is_mem_access;                        // load or store
    logic slot_live;                            // slot really retires this edge

    assign is_mem_access = (ex_mem_op == mem_op_ldw) || (ex_mem_op == mem_op_stw);

    // low address bits must be zero for a word access
    assign miss_align = is_mem_access && (ex_out[byte_off_w-1:0] != '0);

    // word index, upper address bits ignored so it wraps at ram_depth
    assign ram_addr    = ex_out[byte_off_w +: ram_addr_w];
    assign ram_wr_data = ex_mem_wr_data;

    // a stalled or flushed slot must not touch memory
    assign slot_live = (ex_en == enable) && (stall != enable) && (flush != enable);

    assign ram_we = slot_live && (ex_mem_op == mem_op_stw) && !miss_align;

    // stage result
    always_comb begin
        case (ex_mem_op)
            mem_op_ldw: begin
                out = ram_rd_data;              // combinational read
            end
            mem_op_stw: begin
                out = '0;                       // store writes nothing back
            end
            default: begin
                out = ex_out;                   // nop, plain alu op
            end
        endcase
    end

endmodule

//--- logic/mem_reg.sv
`timescale 1ns/1ps

module mem_reg (
    input  logic                            clk,
    input  logic                            reset,          // async, active low
    // result from the memory controller
    input  logic [cpu_pkg::word_data_w-1:0] out,
    input  logic                            miss_align,
    // pipeline control
    input  logic                            stall,
    input  logic                            flush,
    // fields passed on from EX/MEM
    input  logic                            ex_en,
    input  logic [cpu_pkg::reg_addr_w-1:0]  ex_dst_addr,
    input  logic                            ex_gpr_we_,
    // MEM/WB register
    output logic                            mem_en,
    output logic [cpu_pkg::reg_addr_w-1:0]  mem_dst_addr,
    output logic                            mem_gpr_we_,
    output logic [cpu_pkg::word_data_w-1:0] mem_out
);

    import cpu_pkg::*;

    // stall > flush > miss_align > normal update
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mem_en       <= 1'b0;               // bubble
            mem_dst_addr <= '0;
            mem_gpr_we_  <= disable_;
            mem_out      <= '0;
        end else if (stall != enable) begin     // stalled -> hold everything
            if (flush == enable) begin
                mem_en       <= 1'b0;
                mem_dst_addr <= '0;
                mem_gpr_we_  <= disable_;
                mem_out      <= '0;
            end else if (miss_align == enable) begin
                // slot stays valid, write-back killed
                mem_en       <= ex_en;
                mem_dst_addr <= '0;
                mem_gpr_we_  <= disable_;
                mem_out      <= '0;
            end else begin
                mem_en       <= ex_en;
                mem_dst_addr <= ex_dst_addr;
                mem_gpr_we_  <= ex_gpr_we_;
                mem_out      <= out;            // loaded word or alu result
            end
        end
    end

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                            clk,
    input  logic                            reset,          // async, active low
    // pipeline control
    input  logic                            stall,
    input  logic                            flush,
    // EX/MEM register
    input  logic                            ex_en,
    input  cpu_pkg::mem_op_t                ex_mem_op,
    input  logic [cpu_pkg::word_data_w-1:0] ex_out,
    input  logic [cpu_pkg::word_data_w-1:0] ex_mem_wr_data,
    input  logic [cpu_pkg::reg_addr_w-1:0]  ex_dst_addr,
    input  logic                            ex_gpr_we_,
    // MEM/WB register
    output logic                            mem_en,
    output logic [cpu_pkg::reg_addr_w-1:0]  mem_dst_addr,
    output logic                            mem_gpr_we_,
    output logic [cpu_pkg::word_data_w-1:0] mem_out
);

    import cpu_pkg::*;

    // ram port
    logic [ram_addr_w-1:0]  ram_addr;
    logic [word_data_w-1:0] ram_wr_data;
    logic [word_data_w-1:0] ram_rd_data;
    logic                   ram_we;

    // controller -> pipeline register
    logic [word_data_w-1:0] out;
    logic                   miss_align;

    mem_ctrl mem_ctrl_inst (
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_out         (ex_out),
        .ex_mem_wr_data (ex_mem_wr_data),
        .stall          (stall),
        .flush          (flush),
        .ram_rd_data    (ram_rd_data),
        .ram_addr       (ram_addr),
        .ram_wr_data    (ram_wr_data),
        .ram_we         (ram_we),
        .out            (out),
        .miss_align     (miss_align)
    );

    data_ram data_ram_inst (
        .clk     (clk),
        .addr    (ram_addr),
        .wr_data (ram_wr_data),
        .we      (ram_we),
        .rd_data (ram_rd_data)
    );

    // dst addr and write enable bypass the controller
    mem_reg mem_reg_inst (
        .clk          (clk),
        .reset        (reset),
        .out          (out),
        .miss_align   (miss_align),
        .stall        (stall),
        .flush        (flush),
        .ex_en        (ex_en),
        .ex_dst_addr  (ex_dst_addr),
        .ex_gpr_we_   (ex_gpr_we_),
        .mem_en       (mem_en),
        .mem_dst_addr (mem_dst_addr),
        .mem_gpr_we_  (mem_gpr_we_),
        .mem_out      (mem_out)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the MEM stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module mem_stage_tb -f tb.f -o mem_stage_sim

out=$(./obj_dir/mem_stage_sim)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
else
    exit 1
fi

//--- tb.f
logic/cpu_pkg.sv
logic/mem_ctrl.sv
logic/data_ram.sv
logic/mem_reg.sv
logic/mem_stage.sv
verification/clock_gen.sv
verification/mem_stage_tb.sv

//--- verification/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset          // async, active low
);

    localparam int half_period  = 4;        // 8 ns clock
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a rising edge
    initial begin
        reset <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

//--- verification/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    import cpu_pkg::*;

    localparam int num_pairs  = 8;              // store/load pairs
    // slots issued over all tests
    localparam int slot_count = 2 * num_pairs + 8 + 4 * 3 + 2 * 3 + 3;
    localparam int timeout_ns = slot_count * 8 * 4 + 10 * 8;

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic                   flush;
    logic                   ex_en;
    mem_op_t                ex_mem_op;
    logic [word_data_w-1:0] ex_out;
    logic [word_data_w-1:0] ex_mem_wr_data;
    logic [reg_addr_w-1:0]  ex_dst_addr;
    logic                   ex_gpr_we_;
    logic                   mem_en;
    logic [reg_addr_w-1:0]  mem_dst_addr;
    logic                   mem_gpr_we_;
    logic [word_data_w-1:0] mem_out;

    integer seed = 64;
    int     error_count = 0;
    int     check_count = 0;

    logic [31:0] model_mem [ram_depth];         // expected ram contents
    logic [31:0] stored_addr [num_pairs];       // addresses written so far

    clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    mem_stage mem_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .flush          (flush),
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_out         (ex_out),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_dst_addr    (ex_dst_addr),
        .ex_gpr_we_     (ex_gpr_we_),
        .mem_en         (mem_en),
        .mem_dst_addr   (mem_dst_addr),
        .mem_gpr_we_    (mem_gpr_we_),
        .mem_out        (mem_out)
    );

    // byte address -> word slot, wraps at ram depth
    function automatic logic [ram_addr_w-1:0] word_index(input logic [31:0] addr);
        logic [31:0] w;
        w = (addr >> 2) % ram_depth;
        return w[ram_addr_w-1:0];
    endfunction

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    // all four MEM/WB fields at once
    task automatic check_outputs(input string name, input logic en, input logic [4:0] dst,
                                 input logic we_, input logic [31:0] result);
        check_value({name, " mem_en"}, 32'(en), 32'(mem_en));
        check_value({name, " mem_dst_addr"}, 32'(dst), 32'(mem_dst_addr));
        check_value({name, " mem_gpr_we_"}, 32'(we_), 32'(mem_gpr_we_));
        check_value({name, " mem_out"}, result, mem_out);
    endtask

    // empty slot, write-back off
    task automatic drive_idle();
        ex_en          <= 1'b0;
        ex_mem_op      <= mem_op_nop;
        ex_out         <= '0;
        ex_mem_wr_data <= '0;
        ex_dst_addr    <= '0;
        ex_gpr_we_     <= 1'b1;
        stall          <= 1'b0;
        flush          <= 1'b0;
    endtask

    // present one slot, let it retire, sample mid-cycle
    task automatic run_slot(input logic en, input mem_op_t op, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [4:0] dst,
                            input logic we_, input logic flush_v);
        @(posedge clk);
        ex_en          <= en;
        ex_mem_op      <= op;
        ex_out         <= addr;
        ex_mem_wr_data <= wdata;
        ex_dst_addr    <= dst;
        ex_gpr_we_     <= we_;
        stall          <= 1'b0;
        flush          <= flush_v;
        @(posedge clk);                         // slot consumed here
        drive_idle();
        @(negedge clk);
    endtask

    task automatic test_reset();
        repeat (3) @(negedge clk);
        check_outputs("reset during", 1'b0, 5'd0, 1'b1, 32'd0);
        @(posedge reset);
        @(negedge clk);
        check_outputs("reset after", 1'b0, 5'd0, 1'b1, 32'd0);
    endtask

    task automatic test_store_load();
        logic [31:0] tmp;
        logic [31:0] data;
        logic [4:0]  dst;
        for (int i = 0; i < num_pairs; i++) begin
            tmp = $random(seed);
            stored_addr[i] = {tmp[31:2], 2'b00};    // aligned, upper bits random
            data = $random(seed);
            tmp = $random(seed);
            dst = tmp[4:0];
            run_slot(1'b1, mem_op_stw, stored_addr[i], data, dst, tmp[8], 1'b0);
            check_outputs("store", 1'b1, dst, tmp[8], 32'd0);   // store gives no result
            model_mem[word_index(stored_addr[i])] = data;
        end
        for (int i = 0; i < num_pairs; i++) begin
            tmp = $random(seed);
            dst = tmp[4:0];
            run_slot(1'b1, mem_op_ldw, stored_addr[i], tmp, dst, 1'b0, 1'b0);
            check_outputs("load", 1'b1, dst, 1'b0, model_mem[word_index(stored_addr[i])]);
        end
    endtask

    task automatic test_pass_through();
        logic [31:0] alu;
        logic [31:0] tmp;
        for (int i = 0; i < 8; i++) begin
            alu = $random(seed);                // any value, no alignment rule
            tmp = $random(seed);
            run_slot(tmp[0], mem_op_nop, alu, 32'd0, tmp[5:1], tmp[6], 1'b0);
            check_outputs("pass_through", tmp[0], tmp[5:1], tmp[6], alu);
        end
    endtask

    task automatic test_miss_align();
        logic [31:0] base;
        logic [31:0] tmp;
        logic [1:0]  off;
        for (int i = 0; i < 4; i++) begin
            base = stored_addr[i];
            tmp = $random(seed);
            off = tmp[1:0];
            if (off == 2'd0) begin
                off = 2'd1;
            end
            // store with bad address, ram must stay as is
            run_slot(1'b1, mem_op_stw, base | {30'd0, off}, ~tmp, 5'd7, 1'b0, 1'b0);
            check_outputs("miss_align store", 1'b1, 5'd0, 1'b1, 32'd0);
            run_slot(1'b1, mem_op_ldw, base | {30'd0, off}, 32'd0, 5'd8, 1'b0, 1'b0);
            check_outputs("miss_align load", 1'b1, 5'd0, 1'b1, 32'd0);
            run_slot(1'b1, mem_op_ldw, base, 32'd0, 5'd9, 1'b0, 1'b0);
            check_outputs("miss_align reload", 1'b1, 5'd9, 1'b0, model_mem[word_index(base)]);
        end
    endtask

    task automatic test_flush();
        logic [31:0] base;
        for (int i = 0; i < 2; i++) begin
            base = stored_addr[num_pairs - 1 - i];
            run_slot(1'b1, mem_op_ldw, base, 32'd0, 5'd3, 1'b0, 1'b1);
            check_outputs("flush load", 1'b0, 5'd0, 1'b1, 32'd0);
            run_slot(1'b1, mem_op_stw, base, ~model_mem[word_index(base)], 5'd4, 1'b1, 1'b1);
            check_outputs("flush store", 1'b0, 5'd0, 1'b1, 32'd0);
            run_slot(1'b1, mem_op_ldw, base, 32'd0, 5'd5, 1'b0, 1'b0);
            check_outputs("flush reload", 1'b1, 5'd5, 1'b0, model_mem[word_index(base)]);
        end
    endtask

    task automatic test_stall();
        logic [31:0] base;
        logic [31:0] old_word;
        base     = stored_addr[0];
        old_word = model_mem[word_index(base)];
        @(posedge clk);
        ex_en       <= 1'b1;                    // load that the stall must hold
        ex_mem_op   <= mem_op_ldw;
        ex_out      <= base;
        ex_dst_addr <= 5'd9;
        ex_gpr_we_  <= 1'b0;
        @(posedge clk);
        stall          <= 1'b1;                 // store parked behind the stall
        ex_mem_op      <= mem_op_stw;
        ex_mem_wr_data <= ~old_word;
        ex_dst_addr    <= 5'd3;
        ex_gpr_we_     <= 1'b1;
        @(negedge clk);
        check_outputs("stall load", 1'b1, 5'd9, 1'b0, old_word);
        repeat (4) begin
            @(negedge clk);
            check_outputs("stall hold", 1'b1, 5'd9, 1'b0, old_word);
        end
        @(posedge clk);
        stall          <= 1'b0;                 // release with a fresh load
        ex_mem_op      <= mem_op_ldw;
        ex_mem_wr_data <= '0;
        ex_dst_addr    <= 5'd12;
        ex_gpr_we_     <= 1'b0;
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check_outputs("stall release", 1'b1, 5'd12, 1'b0, old_word);
    endtask

    // watchdog
    initial begin
        #(timeout_ns);
        $display("simulation timed out before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        ex_en          <= 1'b0;
        ex_mem_op      <= mem_op_nop;
        ex_out         <= '0;
        ex_mem_wr_data <= '0;
        ex_dst_addr    <= '0;
        ex_gpr_we_     <= 1'b1;
        stall          <= 1'b0;
        flush          <= 1'b0;
        test_reset();
        test_store_load();
        test_pass_through();
        test_miss_align();
        test_flush();
        test_stall();
        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
